//--- hdl/raster_pkg.sv
`default_nettype none

package raster_pkg;

	////////////////////
	// Counter geometry
	////////////////////

	localparam int COORD_W = 11; // Covers totals up to 2047

	typedef logic [COORD_W-1:0] coord_t;

	////////////////////
	// Raster phases
	////////////////////

	// Order follows the line, active first
	typedef enum logic [1:0] {
		PH_ACTIVE = 2'd0, // Live pixels or lines
		PH_FRONT  = 2'd1, // Front porch
		PH_SYNC   = 2'd2, // Sync pulse
		PH_BACK   = 2'd3  // Back porch, then wrap
	} phase_e;

endpackage

`default_nettype wire

//--- hdl/video_mode_pkg.sv
`default_nettype none

package video_mode_pkg;

	localparam int MODE_W = 4; // Mode switch width

	// Switch codes of the board
	typedef enum logic [MODE_W-1:0] {
		MODE_VGA    = 4'b0000,
		MODE_SVGA   = 4'b0001,
		MODE_HD720  = 4'b0010,
		MODE_XGA    = 4'b0011,
		MODE_SXGA   = 4'b1000,
		MODE_CAMERA = 4'b1001
	} mode_e;

	// Porch and sync figures of one format
	typedef struct packed {
		raster_pkg::coord_t h_active;
		raster_pkg::coord_t h_front;
		raster_pkg::coord_t h_sync;
		raster_pkg::coord_t h_back;
		raster_pkg::coord_t v_active;
		raster_pkg::coord_t v_front;
		raster_pkg::coord_t v_sync;
		raster_pkg::coord_t v_back;
		logic               sync_neg; // 1 means active low sync
	} timing_t;

	////////////////////
	// Format table
	////////////////////

	localparam timing_t TIMING_VGA = '{
		h_active: 11'd640, h_front: 11'd16, h_sync: 11'd96, h_back: 11'd48,
		v_active: 11'd480, v_front: 11'd11, v_sync: 11'd2, v_back: 11'd31,
		sync_neg: 1'b1
	};
	localparam timing_t TIMING_SVGA = '{
		h_active: 11'd800, h_front: 11'd40, h_sync: 11'd128, h_back: 11'd88,
		v_active: 11'd600, v_front: 11'd1, v_sync: 11'd4, v_back: 11'd23,
		sync_neg: 1'b0
	};
	localparam timing_t TIMING_XGA = '{
		h_active: 11'd1024, h_front: 11'd24, h_sync: 11'd136, h_back: 11'd160,
		v_active: 11'd768, v_front: 11'd3, v_sync: 11'd6, v_back: 11'd29,
		sync_neg: 1'b1
	};
	localparam timing_t TIMING_HD720 = '{
		h_active: 11'd1280, h_front: 11'd110, h_sync: 11'd40, h_back: 11'd220,
		v_active: 11'd720, v_front: 11'd5, v_sync: 11'd5, v_back: 11'd20,
		sync_neg: 1'b0
	};
	localparam timing_t TIMING_SXGA = '{
		h_active: 11'd1280, h_front: 11'd48, h_sync: 11'd112, h_back: 11'd248,
		v_active: 11'd1024, v_front: 11'd1, v_sync: 11'd3, v_back: 11'd38,
		sync_neg: 1'b0
	};
	localparam timing_t TIMING_CAMERA = '{
		h_active: 11'd1280, h_front: 11'd110, h_sync: 11'd39, h_back: 11'd220,
		v_active: 11'd720, v_front: 11'd4, v_sync: 11'd4, v_back: 11'd22,
		sync_neg: 1'b0
	};

	// Table lookup, 720p for anything else
	function automatic timing_t mode_timing(mode_e mode);
		case (mode)
			MODE_VGA:    return TIMING_VGA;
			MODE_SVGA:   return TIMING_SVGA;
			MODE_XGA:    return TIMING_XGA;
			MODE_SXGA:   return TIMING_SXGA;
			MODE_CAMERA: return TIMING_CAMERA;
			default:     return TIMING_HD720;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- hdl/mode_select.sv
`timescale 1ns/1ps
`default_nettype none

module mode_select #(
	parameter int DEBOUNCE_CYCLES = 65536 // Stable cycles before a code is taken
) (
	input  wire logic                               clk50m_bufg,
	input  wire logic                               rst,
	input  wire logic [video_mode_pkg::MODE_W-1:0] sw,          // Raw board switches
	output video_mode_pkg::mode_e                   mode,
	output logic                                    mode_change  // One cycle, new mode valid
);

	localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

	logic [video_mode_pkg::MODE_W-1:0] sw_meta; // First sync flop
	logic [video_mode_pkg::MODE_W-1:0] sw_sync; // Second sync flop
	logic [CNT_W-1:0]                   stable_cnt;
	logic                               stable;
	video_mode_pkg::mode_e              code_mode;

	////////////////////
	// Synchronizer
	////////////////////

	always_ff @(posedge clk50m_bufg) begin
		sw_meta <= sw;
		sw_sync <= sw_meta;
	end

	////////////////////
	// Debounce
	////////////////////

	assign stable = (stable_cnt == CNT_W'(DEBOUNCE_CYCLES));

	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			stable_cnt <= '0;
		end else if (sw_meta != sw_sync) begin
			stable_cnt <= '0; // Code about to move, start over
		end else if (!stable) begin
			stable_cnt <= stable_cnt + 1'b1; // Saturates at the limit
		end
	end

	// Known codes map straight through
	always_comb begin
		case (sw_sync)
			video_mode_pkg::MODE_VGA,
			video_mode_pkg::MODE_SVGA,
			video_mode_pkg::MODE_HD720,
			video_mode_pkg::MODE_XGA,
			video_mode_pkg::MODE_SXGA,
			video_mode_pkg::MODE_CAMERA: code_mode = video_mode_pkg::mode_e'(sw_sync);
			default:                     code_mode = video_mode_pkg::MODE_HD720; // Fallback
		endcase
	end

	// Commit only on a real change of format
	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			mode        <= video_mode_pkg::MODE_HD720;
			mode_change <= 1'b0;
		end else begin
			mode_change <= 1'b0;
			if (stable && code_mode != mode) begin
				mode        <= code_mode;
				mode_change <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/raster_timing.sv
`timescale 1ns/1ps
`default_nettype none

module raster_timing (
	input  wire logic                  clk50m_bufg,
	input  wire logic                  rst,
	input  wire video_mode_pkg::mode_e mode,
	input  wire logic                  mode_change, // Restarts the raster
	output raster_pkg::coord_t         hcount,
	output raster_pkg::coord_t         vcount,
	output logic                       hsync_raw,   // High during the pulse
	output logic                       vsync_raw,
	output logic                       active,      // Live pixel
	output logic                       sync_neg     // Format wants low sync
);

	video_mode_pkg::timing_t fmt;

	raster_pkg::coord_t h_sync_at; // First pixel of hsync
	raster_pkg::coord_t h_back_at; // First pixel of back porch
	raster_pkg::coord_t h_last;    // Last pixel of the line
	raster_pkg::coord_t v_sync_at;
	raster_pkg::coord_t v_back_at;
	raster_pkg::coord_t v_last;
	raster_pkg::coord_t h_next;
	raster_pkg::coord_t v_next;
	logic               h_wrap;
	raster_pkg::phase_e h_phase;
	raster_pkg::phase_e v_phase;

	// Step to the next phase when the count hits its boundary
	function automatic raster_pkg::phase_e next_phase(
		input raster_pkg::phase_e cur,
		input raster_pkg::coord_t nxt,
		input raster_pkg::coord_t blank_at,
		input raster_pkg::coord_t sync_at,
		input raster_pkg::coord_t back_at
	);
		raster_pkg::phase_e ph;
		ph = cur;
		case (cur)
			raster_pkg::PH_ACTIVE: if (nxt == blank_at) ph = raster_pkg::PH_FRONT;
			raster_pkg::PH_FRONT:  if (nxt == sync_at) ph = raster_pkg::PH_SYNC;
			raster_pkg::PH_SYNC:   if (nxt == back_at) ph = raster_pkg::PH_BACK;
			raster_pkg::PH_BACK:   if (nxt == '0) ph = raster_pkg::PH_ACTIVE;
		endcase
		return ph;
	endfunction

	////////////////////
	// Format boundaries
	////////////////////

	assign fmt = video_mode_pkg::mode_timing(mode);

	assign h_sync_at = fmt.h_active + fmt.h_front;
	assign h_back_at = h_sync_at + fmt.h_sync;
	assign h_last    = h_back_at + fmt.h_back - raster_pkg::coord_t'(1);
	assign v_sync_at = fmt.v_active + fmt.v_front;
	assign v_back_at = v_sync_at + fmt.v_sync;
	assign v_last    = v_back_at + fmt.v_back - raster_pkg::coord_t'(1);

	assign h_wrap = (hcount == h_last);
	assign h_next = h_wrap ? '0 : hcount + 1'b1;
	assign v_next = (vcount == v_last) ? '0 : vcount + 1'b1; // Used only at h_wrap

	////////////////////
	// Counters and FSMs
	////////////////////

	always_ff @(posedge clk50m_bufg) begin
		if (rst || mode_change) begin
			hcount  <= '0;
			vcount  <= '0;
			h_phase <= raster_pkg::PH_ACTIVE;
			v_phase <= raster_pkg::PH_ACTIVE;
		end else begin
			hcount  <= h_next;
			h_phase <= next_phase(h_phase, h_next, fmt.h_active, h_sync_at, h_back_at);
			if (h_wrap) begin // One line done
				vcount  <= v_next;
				v_phase <= next_phase(v_phase, v_next, fmt.v_active, v_sync_at, v_back_at);
			end
		end
	end

	// Decode, aligned with the counters
	assign active    = (h_phase == raster_pkg::PH_ACTIVE) && (v_phase == raster_pkg::PH_ACTIVE);
	assign hsync_raw = (h_phase == raster_pkg::PH_SYNC);
	assign vsync_raw = (v_phase == raster_pkg::PH_SYNC);
	assign sync_neg  = fmt.sync_neg;

endmodule

`default_nettype wire

//--- hdl/video_sync_out.sv
`timescale 1ns/1ps
`default_nettype none

module video_sync_out (
	input  wire logic               clk50m_bufg,
	input  wire logic               rst,
	input  wire raster_pkg::coord_t hcount,
	input  wire raster_pkg::coord_t vcount,
	input  wire logic               hsync_raw,
	input  wire logic               vsync_raw,
	input  wire logic               active,
	input  wire logic               sync_neg,   // Invert both syncs
	output logic                    hsync,      // Board level sync
	output logic                    vsync,
	output logic                    de,
	output raster_pkg::coord_t      hcount_out, // Same 2 cycle lag as de
	output raster_pkg::coord_t      vcount_out
);

	logic               hsync_q; // Polarity applied
	logic               vsync_q;
	logic               active_q;
	raster_pkg::coord_t hcount_q;
	raster_pkg::coord_t vcount_q;

	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			hsync_q    <= 1'b0; // Idle level of 720p
			vsync_q    <= 1'b0;
			active_q   <= 1'b0;
			hcount_q   <= '0;
			vcount_q   <= '0;
			hsync      <= 1'b0;
			vsync      <= 1'b0;
			de         <= 1'b0;
			hcount_out <= '0;
			vcount_out <= '0;
		end else begin
			// Stage 1
			hsync_q    <= hsync_raw ^ sync_neg;
			vsync_q    <= vsync_raw ^ sync_neg;
			active_q   <= active;
			hcount_q   <= hcount;
			vcount_q   <= vcount;
			// Stage 2, drives the pins
			hsync      <= hsync_q;
			vsync      <= vsync_q;
			de         <= active_q;
			hcount_out <= hcount_q;
			vcount_out <= vcount_q;
		end
	end

endmodule

`default_nettype wire

//--- hdl/dvi_timing_top.sv
`timescale 1ns/1ps
`default_nettype none

module dvi_timing_top #(
	parameter int DEBOUNCE_CYCLES = 65536 // Switch settle time in clocks
) (
	input  wire logic                               clk50m_bufg,
	input  wire logic                               rst,
	input  wire logic [video_mode_pkg::MODE_W-1:0] sw,
	output logic                                    hsync,
	output logic                                    vsync,
	output logic                                    de,
	output raster_pkg::coord_t                      hcount_out,
	output raster_pkg::coord_t                      vcount_out
);

	video_mode_pkg::mode_e mode;
	logic                  mode_change;
	raster_pkg::coord_t    hcount;
	raster_pkg::coord_t    vcount;
	logic                  hsync_raw;
	logic                  vsync_raw;
	logic                  active;
	logic                  sync_neg;

	////////////////////
	// Switches to mode
	////////////////////

	mode_select #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_mode_select (
		.clk50m_bufg(clk50m_bufg),
		.rst        (rst),
		.sw         (sw),
		.mode       (mode),
		.mode_change(mode_change)
	);

	// Raster counters and raw decode
	raster_timing u_raster_timing (
		.clk50m_bufg(clk50m_bufg),
		.rst        (rst),
		.mode       (mode),
		.mode_change(mode_change),
		.hcount     (hcount),
		.vcount     (vcount),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.active     (active),
		.sync_neg   (sync_neg)
	);

	// Polarity and output registers
	video_sync_out u_video_sync_out (
		.clk50m_bufg(clk50m_bufg),
		.rst        (rst),
		.hcount     (hcount),
		.vcount     (vcount),
		.hsync_raw  (hsync_raw),
		.vsync_raw  (vsync_raw),
		.active     (active),
		.sync_neg   (sync_neg),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.hcount_out (hcount_out),
		.vcount_out (vcount_out)
	);

endmodule

`default_nettype wire

//--- verification/dvi_timing_assert.sv
`timescale 1ns/1ps
`default_nettype none

module dvi_timing_assert (
	input wire logic               clk50m_bufg,
	input wire logic               rst,
	input wire logic               hsync,
	input wire logic               de,
	input wire raster_pkg::coord_t hcount_out,
	input wire raster_pkg::coord_t vcount_out,
	input wire logic               sync_neg
);

	logic neg_q1; // Polarity delayed like the output stages
	logic neg_q2;

	always_ff @(posedge clk50m_bufg) begin
		if (rst) begin
			neg_q1 <= 1'b0; // 720p after reset
			neg_q2 <= 1'b0;
		end else begin
			neg_q1 <= sync_neg;
			neg_q2 <= neg_q1;
		end
	end

	////////////////////
	// Output properties
	////////////////////

	// No format has more than 1280 live pixels or 1024 live rows
	a_de_rows: assert property (@(posedge clk50m_bufg) disable iff (rst)
		de |-> ((hcount_out < raster_pkg::coord_t'(1280))
			&& (vcount_out < raster_pkg::coord_t'(1024))))
		else $error("de high at pixel %0d of row %0d", hcount_out, vcount_out);

	a_hcount_step: assert property (@(posedge clk50m_bufg) disable iff (rst)
		(hcount_out == $past(hcount_out) + raster_pkg::coord_t'(1)) || (hcount_out == '0))
		else $error("hcount_out jumped to %0d", hcount_out);

	// Sync pulse sits in the blanking
	a_de_sync: assert property (@(posedge clk50m_bufg) disable iff (rst)
		de |-> !(hsync ^ neg_q2))
		else $error("de high during the hsync pulse");

endmodule

bind dvi_timing_top dvi_timing_assert u_timing_assert (
	.clk50m_bufg(clk50m_bufg),
	.rst        (rst),
	.hsync      (hsync),
	.de         (de),
	.hcount_out (hcount_out),
	.vcount_out (vcount_out),
	.sync_neg   (sync_neg)
);

`default_nettype wire

//--- verification/tb_dvi_timing.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dvi_timing;

	localparam int DEBOUNCE_CYCLES   = 16;
	localparam int NUM_TESTS         = 7;
	localparam int FIELDS            = 7;    // Words per pattern line
	localparam int RESET_CYCLES      = 5;
	localparam int FRAME_VSYNC_LINES = 2;    // VGA vsync pulse
	localparam int FRAME_DE_LINES    = 480;  // VGA live lines
	localparam int MARGIN_CYCLES     = 1000;

	// Field offsets in a pattern line
	localparam int F_SW     = 0;
	localparam int F_HTOTAL = 1;
	localparam int F_HLIVE  = 2;
	localparam int F_HSYNC  = 3;
	localparam int F_NEG    = 4;
	localparam int F_VTOTAL = 5;
	localparam int F_FRAME  = 6;

	logic                              clk50m_bufg = 1'b0;
	logic                              rst;
	logic [video_mode_pkg::MODE_W-1:0] sw;
	logic                              hsync;
	logic                              vsync;
	logic                              de;
	raster_pkg::coord_t                hcount_out;
	raster_pkg::coord_t                vcount_out;

	logic [31:0] patterns [0:NUM_TESTS*FIELDS-1];
	int          value_errors = 0;
	int          other_errors = 0;
	int          cycle_count  = 0;
	int          cycle_limit  = 0; // Zero until the pattern file is read

	dvi_timing_top #(
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)
	) u_dut (
		.clk50m_bufg(clk50m_bufg),
		.rst        (rst),
		.sw         (sw),
		.hsync      (hsync),
		.vsync      (vsync),
		.de         (de),
		.hcount_out (hcount_out),
		.vcount_out (vcount_out)
	);

	always #10 clk50m_bufg = ~clk50m_bufg; // 50 MHz

	////////////////////
	// Helpers
	////////////////////

	function automatic int pattern_field(input int test, input int idx);
		return int'(patterns[test*FIELDS+idx]);
	endfunction

	// Four lines per test, two frames for a frame test
	function automatic int budget_cycles();
		int total;
		int t;
		total = MARGIN_CYCLES;
		for (t = 0; t < NUM_TESTS; t++) begin
			total += 4 * pattern_field(t, F_HTOTAL);
			if (pattern_field(t, F_FRAME) != 0)
				total += 2 * pattern_field(t, F_HTOTAL) * pattern_field(t, F_VTOTAL);
		end
		return total;
	endfunction

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected) else begin
			$display("CHECK FAILED time %0t: %s is %0d, expected %0d", $time, name, got, expected);
			value_errors++;
		end
	endtask

	task automatic expect_true(input bit cond, input string what);
		assert (cond) else begin
			$display("ERROR time %0t: %s", $time, what);
			other_errors++;
		end
	endtask

	task automatic print_error_counts();
		$display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
	endtask

	task automatic check_idle_outputs();
		check_value("de", int'(de), 0);
		check_value("hsync", int'(hsync), 0);
		check_value("vsync", int'(vsync), 0);
	endtask

	// Restart shows as a jump into row 0, column 0
	task automatic wait_for_restart(input int limit, output bit seen);
		int n;
		bit at_origin;
		bit was_origin;
		seen = 1'b0;
		n    = 0;
		@(negedge clk50m_bufg);
		was_origin = (hcount_out == '0) && (vcount_out == '0);
		while (!seen && n < limit) begin
			@(negedge clk50m_bufg);
			at_origin  = (hcount_out == '0) && (vcount_out == '0);
			seen       = at_origin && !was_origin;
			was_origin = at_origin;
			n++;
		end
	endtask

	// Starts on the first sample of a new raster, covers two lines
	task automatic measure_lines(input int t);
		int h_total;
		int neg;
		int c;
		int de_cycles;
		int first_de_h;
		int rise1;
		int rise2;
		int fall1;
		bit act;
		bit prev_act;
		h_total    = pattern_field(t, F_HTOTAL);
		neg        = pattern_field(t, F_NEG);
		de_cycles  = 0;
		first_de_h = -1;
		rise1      = -1;
		rise2      = -1;
		fall1      = -1;
		check_value("hsync idle level", int'(hsync), neg);
		prev_act = hsync ^ neg[0];
		for (c = 0; c < 2 * h_total; c++) begin
			if (c > 0)
				@(negedge clk50m_bufg);
			act = hsync ^ neg[0]; // High while the pulse runs
			if (c < h_total && de) begin
				if (first_de_h < 0)
					first_de_h = int'(hcount_out);
				de_cycles++;
			end
			if (c == h_total) begin // Second line, row 1 column 0
				check_value("hcount_out after one line", int'(hcount_out), 0);
				check_value("vcount_out after one line", int'(vcount_out), 1);
			end
			if (act && !prev_act) begin
				if (rise1 < 0)
					rise1 = c;
				else if (rise2 < 0)
					rise2 = c;
			end
			if (!act && prev_act && rise1 >= 0 && fall1 < 0)
				fall1 = c;
			prev_act = act;
		end
		expect_true(rise2 >= 0 && fall1 >= 0, "hsync did not pulse twice within two lines");
		if (rise2 >= 0 && fall1 >= 0) begin
			check_value("hsync period", rise2 - rise1, h_total);
			check_value("hsync width", fall1 - rise1, pattern_field(t, F_HSYNC));
		end
		check_value("de cycles per line", de_cycles, pattern_field(t, F_HLIVE));
		check_value("hcount_out at de rise", first_de_h, 0);
	endtask

	// First vsync edge comes late in the frame
	task automatic measure_frame(input int t);
		int h_total;
		int v_total;
		int neg;
		int n;
		int limit;
		int rise1;
		int rise2;
		int fall1;
		int de_lines;
		bit act;
		bit prev_act;
		bit prev_de;
		h_total  = pattern_field(t, F_HTOTAL);
		v_total  = pattern_field(t, F_VTOTAL);
		neg      = pattern_field(t, F_NEG);
		limit    = 2 * h_total * v_total;
		rise1    = -1;
		rise2    = -1;
		fall1    = -1;
		de_lines = 0;
		n        = 0;
		prev_act = vsync ^ neg[0];
		prev_de  = de;
		while (rise2 < 0 && n < limit) begin
			@(negedge clk50m_bufg);
			n++;
			act = vsync ^ neg[0];
			if (act && !prev_act) begin
				if (rise1 < 0)
					rise1 = n;
				else
					rise2 = n;
			end
			if (!act && prev_act && rise1 >= 0 && fall1 < 0)
				fall1 = n;
			if (de && !prev_de && rise1 >= 0 && rise2 < 0)
				de_lines++; // One de rise per live line
			prev_act = act;
			prev_de  = de;
		end
		expect_true(rise2 >= 0 && fall1 >= 0, "vsync did not pulse twice within two frames");
		if (rise2 >= 0 && fall1 >= 0) begin
			check_value("vsync period", rise2 - rise1, h_total * v_total);
			check_value("vsync width", fall1 - rise1, FRAME_VSYNC_LINES * h_total);
			check_value("lines with de", de_lines, FRAME_DE_LINES);
		end
	endtask

	////////////////////
	// Watchdog
	////////////////////

	always @(posedge clk50m_bufg) begin
		cycle_count <= cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: tests still running after %0d clock cycles", cycle_count);
			print_error_counts();
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int                                t;
		bit                                restarted;
		logic [video_mode_pkg::MODE_W-1:0] code;
		rst = 1'b1;
		sw  = video_mode_pkg::MODE_HD720; // Same as the reset mode
		$readmemh("verification/mode_patterns.txt", patterns);
		for (t = 0; t < NUM_TESTS; t++)
			expect_true(pattern_field(t, F_HTOTAL) > 0, "pattern line has no horizontal total");
		cycle_limit = budget_cycles();

		// Reset levels, held and just after release
		repeat (RESET_CYCLES - 1) begin
			@(negedge clk50m_bufg);
			check_idle_outputs();
		end
		@(posedge clk50m_bufg);
		rst <= 1'b0;
		repeat (2) begin
			@(negedge clk50m_bufg);
			check_idle_outputs();
		end

		for (t = 0; t < NUM_TESTS; t++) begin
			code = patterns[t*FIELDS+F_SW][video_mode_pkg::MODE_W-1:0];
			@(posedge clk50m_bufg);
			sw <= code;
			wait_for_restart(DEBOUNCE_CYCLES + 2 * pattern_field(t, F_HTOTAL), restarted);
			expect_true(restarted, "raster did not restart after the switch change");
			if (restarted) begin
				measure_lines(t);
				if (pattern_field(t, F_FRAME) != 0)
					measure_frame(t);
			end
		end

		print_error_counts();
		if (value_errors == 0 && other_errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/mode_patterns.txt
// One test per line, all fields in hex
// sw  h_total  h_live  h_sync  sync_neg  v_total  full_frame
// Order keeps every code a real change of format
0 320 280 60 1 20c 1 // VGA, whole frame measured
1 420 320 80 0 274 0 // SVGA
5 672 500 28 0 2ee 0 // Unknown code, 720p figures
3 540 400 88 1 326 0 // XGA
2 672 500 28 0 2ee 0 // 720p
8 698 500 70 0 42a 0 // SXGA
9 671 500 27 0 2ee 0 // Camera

//--- list.f
hdl/raster_pkg.sv
hdl/video_mode_pkg.sv
hdl/mode_select.sv
hdl/raster_timing.sv
hdl/video_sync_out.sv
hdl/dvi_timing_top.sv
verification/dvi_timing_assert.sv
verification/tb_dvi_timing.sv

//--- run_sim.sh
#!/bin/sh
# Verilator build and run of the DVI timing testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_dvi_timing -Mdir obj_dir -f list.f || exit 1

sim_out="$(./obj_dir/Vtb_dvi_timing 2>&1)"
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
